/* wb_subsys.f */
src/wb_pkg.sv
src/stage_if.sv
src/scalar_exec.sv
src/mem_data_stage.sv
src/writeback_stage.sv
src/wb_subsys_top.sv
testbench/tb_wb_subsys.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_wb_subsys -f wb_subsys.f -o sim

# The run fails unless the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^All checks passed$$"

clean:
	rm -rf obj_dir

/* testbench/tb_wb_subsys.sv */
// Testbench for the vector back end
// Random stimulus against a reference model of the writeback, rollback and fault rules

`timescale 1ns/1ps
`default_nettype none

module tb_wb_subsys import wb_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 3000;
	localparam int TEST_COUNT = 7;

	typedef struct packed
	{
		logic valid;
		logic [2:0] test_id;
		logic wb_en;
		vector_t wb_value;
		lane_mask_t wb_mask;
		register_idx_t wb_reg;
		thread_idx_t wb_thread;
		logic wb_vec;
		logic rb_en;
		scalar_t rb_pc;
		pipeline_sel_t rb_pipe;
		thread_idx_t rb_thread;
		logic fault;
		scalar_t fault_addr;
	} expect_t;

	logic clk;
	logic reset;
	logic issue_valid;
	exec_op_t issue_op;
	thread_idx_t issue_thread;
	register_idx_t issue_dest_reg;
	logic issue_dest_is_vector;
	lane_mask_t issue_mask;
	scalar_t issue_pc;
	vector_t issue_src_a;
	vector_t issue_src_b;
	line_index_t issue_addr_line;
	byte_offset_t issue_addr_offset;
	subcycle_t issue_subcycle;
	logic fill_en;
	line_index_t fill_index;
	vector_t fill_data;

	logic writeback_en;
	thread_idx_t writeback_thread;
	logic writeback_is_vector;
	vector_t writeback_value;
	lane_mask_t writeback_mask;
	register_idx_t writeback_reg;
	logic rollback_en;
	thread_idx_t rollback_thread;
	scalar_t rollback_pc;
	pipeline_sel_t rollback_pipeline;
	logic fault;
	fault_reason_t fault_reason;
	scalar_t fault_address;
	logic perf_instruction_retire;

	logic [31:0] rng_state = 32'hf57c;
	logic [127:0] model_lines [LINE_COUNT];
	logic [LINE_COUNT-1:0] model_valid;
	expect_t exp_q [$];
	expect_t rb_stage;
	expect_t wb_stage;
	int current_test;
	int cycle_count;
	int check_count [TEST_COUNT];
	int error_count [TEST_COUNT];
	string test_names [TEST_COUNT] = '{"reset", "arith", "branch_call", "illegal",
		"scalar_load", "block_gather", "miss_replay"};
	exec_op_t scalar_loads [5] = '{OP_LOAD_B, OP_LOAD_BX, OP_LOAD_S, OP_LOAD_SX, OP_LOAD_W};

	wb_subsys_top u_dut(.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic vector_t rand_vector();
		vector_t v;
		for (int k = 0; k < VECTOR_LANES; k++)
			v[k] = next_random();
		return v;
	endfunction

	function automatic scalar_t rand_pc();
		logic [31:0] r;
		r = next_random();
		return {r[31:2], 2'b00};
	endfunction

	// Keeps clear of REG_PC so that ordinary writes stay writes
	function automatic register_idx_t rand_dest();
		return register_idx_t'(next_random() % 32'd31);
	endfunction

	// Word 0 is the most significant word of the line, byte 0 the top byte of a word
	function automatic scalar_t line_word(input logic [127:0] line, input int w);
		return line[127 - 32 * w -: 32];
	endfunction

	function automatic logic [7:0] byte_of(input scalar_t word, input int b);
		return word[31 - 8 * b -: 8];
	endfunction

	function automatic scalar_t reverse_bytes(input scalar_t word);
		return {byte_of(word, 3), byte_of(word, 2), byte_of(word, 1), byte_of(word, 0)};
	endfunction

	function automatic scalar_t load_value(input exec_op_t op, input logic [127:0] line,
		input byte_offset_t offset);
		scalar_t word;
		logic [7:0] b;
		logic [15:0] h;
		int hi;
		word = line_word(line, int'(offset[3:2]));
		b = byte_of(word, int'(offset[1:0]));
		hi = offset[1] ? 2 : 0;
		h = {byte_of(word, hi + 1), byte_of(word, hi)};
		case (op)
			OP_LOAD_B: return {24'h0, b};
			OP_LOAD_BX: return {{24{b[7]}}, b};
			OP_LOAD_S: return {16'h0, h};
			OP_LOAD_SX: return {{16{h[15]}}, h};
			default: return reverse_bytes(word);
		endcase
	endfunction

	// Expected outcome of the instruction now on the issue inputs
	function automatic expect_t predict();
		expect_t e;
		scalar_t lane_a;
		scalar_t lane_b;
		scalar_t value;
		logic pc_dest;
		e = '0;
		e.valid = 1'b1;
		e.test_id = 3'(current_test);
		e.wb_thread = issue_thread;
		e.wb_reg = issue_dest_reg;
		e.wb_vec = issue_dest_is_vector;
		e.wb_mask = issue_mask;
		e.rb_thread = issue_thread;
		pc_dest = !issue_dest_is_vector && issue_dest_reg == REG_PC;
		case (issue_op)
			OP_ADD, OP_SUB, OP_CMP_EQ, OP_CMP_LT:
			begin
				for (int k = 0; k < VECTOR_LANES; k++)
				begin
					lane_a = issue_src_a[k];
					lane_b = issue_src_b[k];
					if (issue_op == OP_ADD)
						e.wb_value[k] = lane_a + lane_b;
					else if (issue_op == OP_SUB)
						e.wb_value[k] = lane_a - lane_b;
					else if (issue_op == OP_CMP_EQ)
						e.wb_value[0][k] = lane_a == lane_b;
					else
						e.wb_value[0][k] = $signed(lane_a) < $signed(lane_b);
				end
				if (pc_dest)
				begin
					e.rb_en = 1'b1;
					e.rb_pc = e.wb_value[0];
				end
			end

			OP_BRANCH, OP_CALL:
			begin
				e.rb_en = 1'b1;
				e.rb_pc = issue_src_b[0];
				e.wb_value = {VECTOR_LANES{issue_pc + 32'd4}};
			end

			OP_ILLEGAL:
			begin
				e.rb_en = 1'b1;
				e.rb_pc = FAULT_VECTOR_PC;
				e.fault = 1'b1;
				e.fault_addr = issue_pc;
			end

			default:
			begin
				value = load_value(issue_op, model_lines[issue_addr_line], issue_addr_offset);
				e.wb_value = {VECTOR_LANES{value}};
				e.wb_mask = '1;
				if (issue_op == OP_LOAD_BLOCK)
				begin
					e.wb_mask = issue_mask;
					for (int k = 0; k < VECTOR_LANES; k++)
						e.wb_value[k] = reverse_bytes(line_word(model_lines[issue_addr_line],
							LINE_WORDS - 1 - k));
				end
				else if (issue_op == OP_LOAD_GATHER)
				begin
					// Only the lane named by subcycle may stay enabled
					for (int k = 0; k < VECTOR_LANES; k++)
						e.wb_mask[k] = issue_mask[k] && k == int'(issue_subcycle);
				end
				if (!model_valid[issue_addr_line] || pc_dest)
				begin
					e.rb_en = 1'b1;
					e.rb_pipe = PIPE_MEM;
					e.rb_pc = model_valid[issue_addr_line] ? value : issue_pc;
				end
			end
		endcase
		e.wb_en = !e.rb_en || issue_op == OP_CALL;
		return e;
	endfunction

	task automatic check_field(input int id, input string field, input logic [127:0] expected,
		input logic [127:0] actual);
		check_count[id]++;
		assert (actual === expected)
		else
		begin
			error_count[id]++;
			$display("MISMATCH %s %s: expected %h actual %h", test_names[id], field,
				expected, actual);
		end
	endtask

	task automatic check_retire(input expect_t e);
		int id;
		id = e.valid ? int'(e.test_id) : current_test;
		check_field(id, "retire", 128'(e.valid), 128'(perf_instruction_retire));
		check_field(id, "rollback_en", 128'(e.rb_en), 128'(rollback_en));
		if (e.rb_en)
		begin
			check_field(id, "rollback_pc", 128'(e.rb_pc), 128'(rollback_pc));
			check_field(id, "rollback_pipeline", 128'(e.rb_pipe), 128'(rollback_pipeline));
			check_field(id, "rollback_thread", 128'(e.rb_thread), 128'(rollback_thread));
		end
		check_field(id, "fault", 128'(e.fault), 128'(fault));
		if (e.fault)
		begin
			check_field(id, "fault_reason", 128'(FR_ILLEGAL_INSTRUCTION), 128'(fault_reason));
			check_field(id, "fault_address", 128'(e.fault_addr), 128'(fault_address));
		end
	endtask

	task automatic check_writeback(input expect_t e);
		int id;
		id = e.valid ? int'(e.test_id) : current_test;
		check_field(id, "writeback_en", 128'(e.wb_en), 128'(writeback_en));
		if (e.wb_en)
		begin
			check_field(id, "writeback_value", e.wb_value, writeback_value);
			check_field(id, "writeback_mask", 128'(e.wb_mask), 128'(writeback_mask));
			check_field(id, "writeback_reg", 128'(e.wb_reg), 128'(writeback_reg));
			check_field(id, "writeback_thread", 128'(e.wb_thread), 128'(writeback_thread));
			check_field(id, "writeback_is_vector", 128'(e.wb_vec), 128'(writeback_is_vector));
		end
	endtask

	// Rollback shows one edge after issue, the register write one edge later
	always @(posedge clk)
	begin
		if (reset)
		begin
			rb_stage = '0;
			wb_stage = '0;
		end
		else
		begin
			check_retire(rb_stage);
			check_writeback(wb_stage);
			wb_stage = rb_stage;
			if (exp_q.size() > 0)
				rb_stage = exp_q.pop_front();
			else
				rb_stage = '0;
		end
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, the stimulus never completed", cycle_count);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic reset_dut();
		@(negedge clk);
		reset = 1'b1;
		issue_valid = 1'b0;
		fill_en = 1'b0;
		model_valid = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		issue_valid = 1'b0;
		fill_en = 1'b0;
	endtask

	task automatic fill_line(input line_index_t index, input vector_t data);
		@(negedge clk);
		issue_valid = 1'b0;
		fill_en = 1'b1;
		fill_index = index;
		fill_data = data;
		model_lines[index] = data;
		model_valid[index] = 1'b1;
	endtask

	task automatic issue_arith(input exec_op_t op, input thread_idx_t thread,
		input register_idx_t dest, input logic is_vec, input lane_mask_t mask,
		input scalar_t pc, input vector_t a, input vector_t b);
		@(negedge clk);
		fill_en = 1'b0;
		issue_valid = 1'b1;
		issue_op = op;
		issue_thread = thread;
		issue_dest_reg = dest;
		issue_dest_is_vector = is_vec;
		issue_mask = mask;
		issue_pc = pc;
		issue_src_a = a;
		issue_src_b = b;
		exp_q.push_back(predict());
	endtask

	task automatic issue_load(input exec_op_t op, input thread_idx_t thread,
		input register_idx_t dest, input logic is_vec, input lane_mask_t mask,
		input scalar_t pc, input line_index_t line, input byte_offset_t offset,
		input subcycle_t sub);
		@(negedge clk);
		fill_en = 1'b0;
		issue_valid = 1'b1;
		issue_op = op;
		issue_thread = thread;
		issue_dest_reg = dest;
		issue_dest_is_vector = is_vec;
		issue_mask = mask;
		issue_pc = pc;
		issue_addr_line = line;
		issue_addr_offset = offset;
		issue_subcycle = sub;
		exp_q.push_back(predict());
	endtask

	task automatic finish_test(input int id);
		repeat (3) idle_cycle();
		$display("Test %0d %s: %s, %0d checks, %0d errors", id, test_names[id],
			error_count[id] == 0 ? "PASS" : "FAIL", check_count[id], error_count[id]);
	endtask

	initial
	begin
		logic [31:0] r;
		vector_t a;
		vector_t b;
		scalar_t pc;
		line_index_t line;
		int total_checks;
		int total_errors;

		reset = 1'b1;
		issue_valid = 1'b0;
		issue_op = OP_ADD;
		issue_thread = '0;
		issue_dest_reg = '0;
		issue_dest_is_vector = 1'b0;
		issue_mask = '0;
		issue_pc = '0;
		issue_src_a = '0;
		issue_src_b = '0;
		issue_addr_line = '0;
		issue_addr_offset = '0;
		issue_subcycle = '0;
		fill_en = 1'b0;
		fill_index = '0;
		fill_data = '0;
		model_valid = '0;
		current_test = 0;
		cycle_count = 0;
		for (int t = 0; t < TEST_COUNT; t++)
		begin
			check_count[t] = 0;
			error_count[t] = 0;
		end
		reset_dut();

		// Idle cycles straight after reset expect every output low
		finish_test(0);

		// Lanes of b copy lanes of a at random so that equal compares occur
		current_test = 1;
		for (int i = 0; i < 40; i++)
		begin
			r = next_random();
			a = rand_vector();
			b = rand_vector();
			for (int k = 0; k < VECTOR_LANES; k++)
				if (r[8 + k])
					b[k] = a[k];
			issue_arith(exec_op_t'({2'b00, r[1:0]}), r[4], rand_dest(), r[5], r[15:12],
				rand_pc(), a, b);
		end
		finish_test(1);

		current_test = 2;
		for (int i = 0; i < 6; i++)
		begin
			r = next_random();
			issue_arith(OP_BRANCH, r[4], rand_dest(), r[5], r[15:12], rand_pc(),
				rand_vector(), rand_vector());
			idle_cycle();
			issue_arith(OP_CALL, r[6], rand_dest(), r[7], r[19:16], rand_pc(),
				rand_vector(), rand_vector());
			idle_cycle();
			issue_arith(OP_ADD, r[8], REG_PC, 1'b0, r[23:20], rand_pc(),
				rand_vector(), rand_vector());
			idle_cycle();
		end
		finish_test(2);

		current_test = 3;
		for (int i = 0; i < 4; i++)
		begin
			r = next_random();
			issue_arith(OP_ILLEGAL, r[4], rand_dest(), r[5], r[15:12], rand_pc(),
				rand_vector(), rand_vector());
			idle_cycle();
		end
		finish_test(3);

		current_test = 4;
		for (int l = 0; l < LINE_COUNT; l++)
			fill_line(line_index_t'(l), rand_vector());
		for (int op_i = 0; op_i < 5; op_i++)
			for (int off = 0; off < LINE_BYTES; off++)
			begin
				r = next_random();
				issue_load(scalar_loads[op_i], r[4], rand_dest(), r[5], r[15:12], rand_pc(),
					r[18:16], byte_offset_t'(off), r[21:20]);
			end
		finish_test(4);

		current_test = 5;
		for (int i = 0; i < 8; i++)
		begin
			r = next_random();
			issue_load(OP_LOAD_BLOCK, r[4], rand_dest(), 1'b1, r[15:12], rand_pc(),
				r[18:16], r[27:24], r[21:20]);
		end
		for (int i = 0; i < 12; i++)
		begin
			r = next_random();
			issue_load(OP_LOAD_GATHER, r[4], rand_dest(), 1'b1, r[15:12], rand_pc(),
				r[18:16], r[27:24], r[21:20]);
		end
		finish_test(5);

		// Reset clears every valid bit, so the first load of each line misses
		current_test = 6;
		reset_dut();
		for (int i = 0; i < 3; i++)
		begin
			r = next_random();
			pc = rand_pc();
			line = line_index_t'(2 * i + 1);
			issue_load(OP_LOAD_W, r[4], rand_dest(), r[5], r[15:12], pc, line, r[27:24],
				r[21:20]);
			idle_cycle();
			fill_line(line, rand_vector());
			issue_load(OP_LOAD_W, r[4], rand_dest(), r[5], r[15:12], pc, line, r[27:24],
				r[21:20]);
			idle_cycle();
			issue_load(OP_LOAD_B, r[6], REG_PC, 1'b0, r[15:12], rand_pc(), line, r[31:28],
				r[21:20]);
			idle_cycle();
		end
		finish_test(6);

		total_checks = 0;
		total_errors = 0;
		for (int t = 0; t < TEST_COUNT; t++)
		begin
			total_checks += check_count[t];
			total_errors += error_count[t];
		end
		$display("Summary: %0d checks, %0d errors", total_checks, total_errors);
		if (total_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* src/wb_subsys_top.sv */
// Vector back end top level
// Arithmetic and memory pipelines side by side feeding one writeback stage

`timescale 1ns/1ps
`default_nettype none

module wb_subsys_top import wb_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	input wire logic issue_valid,
	input wire exec_op_t issue_op,
	input wire thread_idx_t issue_thread,
	input wire register_idx_t issue_dest_reg,
	input wire logic issue_dest_is_vector,
	input wire lane_mask_t issue_mask,
	input wire scalar_t issue_pc,
	input wire vector_t issue_src_a,
	input wire vector_t issue_src_b,
	input wire line_index_t issue_addr_line,
	input wire byte_offset_t issue_addr_offset,
	input wire subcycle_t issue_subcycle,

	input wire logic fill_en,
	input wire line_index_t fill_index,
	input wire vector_t fill_data,

	output logic writeback_en,
	output thread_idx_t writeback_thread,
	output logic writeback_is_vector,
	output vector_t writeback_value,
	output lane_mask_t writeback_mask,
	output register_idx_t writeback_reg,
	output logic rollback_en,
	output thread_idx_t rollback_thread,
	output scalar_t rollback_pc,
	output pipeline_sel_t rollback_pipeline,
	output logic fault,
	output fault_reason_t fault_reason,
	output scalar_t fault_address,
	output logic perf_instruction_retire
);

	exec_result_if sx_result();
	mem_result_if dd_result();

	scalar_exec u_scalar_exec(
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_op(issue_op),
		.issue_thread(issue_thread),
		.issue_dest_reg(issue_dest_reg),
		.issue_dest_is_vector(issue_dest_is_vector),
		.issue_mask(issue_mask),
		.issue_pc(issue_pc),
		.issue_src_a(issue_src_a),
		.issue_src_b(issue_src_b),
		.out(sx_result.source));

	mem_data_stage u_mem_data_stage(
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_op(issue_op),
		.issue_thread(issue_thread),
		.issue_dest_reg(issue_dest_reg),
		.issue_dest_is_vector(issue_dest_is_vector),
		.issue_mask(issue_mask),
		.issue_pc(issue_pc),
		.issue_addr_line(issue_addr_line),
		.issue_addr_offset(issue_addr_offset),
		.issue_subcycle(issue_subcycle),
		.fill_en(fill_en),
		.fill_index(fill_index),
		.fill_data(fill_data),
		.out(dd_result.source));

	writeback_stage u_writeback_stage(
		.clk(clk),
		.reset(reset),
		.sx(sx_result.sink),
		.dd(dd_result.sink),
		.writeback_en(writeback_en),
		.writeback_thread(writeback_thread),
		.writeback_is_vector(writeback_is_vector),
		.writeback_value(writeback_value),
		.writeback_mask(writeback_mask),
		.writeback_reg(writeback_reg),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.rollback_pc(rollback_pc),
		.rollback_pipeline(rollback_pipeline),
		.fault(fault),
		.fault_reason(fault_reason),
		.fault_address(fault_address),
		.perf_instruction_retire(perf_instruction_retire));

endmodule

`default_nettype wire

/* src/writeback_stage.sv */
// Writeback stage
// Load alignment, rollback and fault priority, registered register write port

`timescale 1ns/1ps
`default_nettype none

module writeback_stage import wb_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	exec_result_if.sink sx,
	mem_result_if.sink dd,

	output logic writeback_en,
	output thread_idx_t writeback_thread,
	output logic writeback_is_vector,
	output vector_t writeback_value,
	output lane_mask_t writeback_mask,
	output register_idx_t writeback_reg,

	output logic rollback_en,
	output thread_idx_t rollback_thread,
	output scalar_t rollback_pc,
	output pipeline_sel_t rollback_pipeline,

	output logic fault,
	output fault_reason_t fault_reason,
	output scalar_t fault_address,

	output logic perf_instruction_retire
);

	localparam int WORD_SEL_W = $clog2(LINE_WORDS);

	logic [WORD_SEL_W-1:0] word_sel;
	scalar_t load_word;
	logic [7:0] byte_aligned;
	logic [15:0] half_aligned;
	scalar_t aligned_value;
	vector_t swapped_line;
	lane_mask_t gather_mask;
	logic sx_illegal;
	logic sx_pc_write;
	logic dd_pc_write;
	logic wb_en_next;
	thread_idx_t wb_thread_next;
	logic wb_is_vector_next;
	vector_t wb_value_next;
	lane_mask_t wb_mask_next;
	register_idx_t wb_reg_next;

	function automatic scalar_t byte_swap(input scalar_t word);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

	// Word 0 of a line is the most significant one
	assign word_sel = WORD_SEL_W'(LINE_WORDS - 1) - dd.offset[$bits(byte_offset_t)-1:2];
	assign load_word = dd.line_data[word_sel];

	// Byte 0 is the top byte of the word
	always_comb
	begin
		case (dd.offset[1:0])
			2'd0: byte_aligned = load_word[31:24];
			2'd1: byte_aligned = load_word[23:16];
			2'd2: byte_aligned = load_word[15:8];
			default: byte_aligned = load_word[7:0];
		endcase
	end

	assign half_aligned = dd.offset[1] ? {load_word[7:0], load_word[15:8]}
		: {load_word[23:16], load_word[31:24]};

	always_comb
	begin
		case (dd.op)
			OP_LOAD_B: aligned_value = {24'b0, byte_aligned};
			OP_LOAD_BX: aligned_value = {{24{byte_aligned[7]}}, byte_aligned};
			OP_LOAD_S: aligned_value = {16'b0, half_aligned};
			OP_LOAD_SX: aligned_value = {{16{half_aligned[15]}}, half_aligned};
			default: aligned_value = byte_swap(load_word);
		endcase
	end

	// Lane k takes word LINE_WORDS-1-k, which is storage slot k
	always_comb
	begin
		for (int lane = 0; lane < VECTOR_LANES; lane++)
			swapped_line[lane] = byte_swap(dd.line_data[lane]);
	end

	assign gather_mask = dd.mask & (lane_mask_t'(1) << dd.subcycle);

	assign sx_illegal = sx.valid && sx.op == OP_ILLEGAL;
	assign sx_pc_write = sx.valid && (sx.op inside {OP_ADD, OP_SUB, OP_CMP_EQ, OP_CMP_LT})
		&& !sx.dest_is_vector && sx.dest_reg == REG_PC;
	assign dd_pc_write = dd.valid && !dd.miss && !dd.dest_is_vector && dd.dest_reg == REG_PC;

	assign perf_instruction_retire = sx.valid || dd.valid;

	// Only one pipeline retires per cycle, so one rollback source at a time
	always_comb
	begin
		rollback_en = 1'b0;
		rollback_thread = '0;
		rollback_pc = '0;
		rollback_pipeline = PIPE_SCYCLE_ARITH;
		fault = 1'b0;
		fault_reason = FR_NONE;
		fault_address = '0;

		if (sx_illegal)
		begin
			rollback_en = 1'b1;
			rollback_thread = sx.thread;
			rollback_pc = FAULT_VECTOR_PC;
			fault = 1'b1;
			fault_reason = FR_ILLEGAL_INSTRUCTION;
			fault_address = sx.pc;
		end
		else if (sx_pc_write)
		begin
			rollback_en = 1'b1;
			rollback_thread = sx.thread;
			rollback_pc = sx.result[0];
		end
		else if (dd_pc_write)
		begin
			rollback_en = 1'b1;
			rollback_thread = dd.thread;
			rollback_pc = aligned_value;
			rollback_pipeline = PIPE_MEM;
		end
		else if (sx.valid && sx.rollback_en)
		begin
			rollback_en = 1'b1;
			rollback_thread = sx.thread;
			rollback_pc = sx.result[0];
		end
		else if (dd.valid && dd.miss)
		begin
			// Replay the load once the line is present
			rollback_en = 1'b1;
			rollback_thread = dd.thread;
			rollback_pc = dd.pc;
			rollback_pipeline = PIPE_MEM;
		end
	end

	always_comb
	begin
		wb_en_next = 1'b0;
		wb_thread_next = sx.thread;
		wb_is_vector_next = sx.dest_is_vector;
		wb_value_next = sx.result;
		wb_mask_next = sx.mask;
		wb_reg_next = sx.dest_reg;

		if (sx.valid)
		begin
			// A call rolls back and still writes its link register
			wb_en_next = sx.op == OP_CALL || !rollback_en;
			if (sx.op == OP_CALL)
				wb_value_next = {VECTOR_LANES{sx.result[1]}};
		end
		else if (dd.valid)
		begin
			wb_en_next = !rollback_en;
			wb_thread_next = dd.thread;
			wb_is_vector_next = dd.dest_is_vector;
			wb_reg_next = dd.dest_reg;
			case (dd.op)
				OP_LOAD_BLOCK:
				begin
					wb_value_next = swapped_line;
					wb_mask_next = dd.mask;
				end

				OP_LOAD_GATHER:
				begin
					wb_value_next = {VECTOR_LANES{aligned_value}};
					wb_mask_next = gather_mask;
				end

				default:
				begin
					wb_value_next = {VECTOR_LANES{aligned_value}};
					wb_mask_next = '1;
				end
			endcase
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			writeback_en <= 1'b0;
		else
			writeback_en <= wb_en_next;
	end

	always_ff @(posedge clk)
	begin
		writeback_thread <= wb_thread_next;
		writeback_is_vector <= wb_is_vector_next;
		writeback_value <= wb_value_next;
		writeback_mask <= wb_mask_next;
		writeback_reg <= wb_reg_next;
	end

endmodule

`default_nettype wire

/* src/mem_data_stage.sv */
// Memory data pipeline
// Small line store with per-line valid bits, one line read per load, misses flagged

`timescale 1ns/1ps
`default_nettype none

module mem_data_stage import wb_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic issue_valid,
	input wire exec_op_t issue_op,
	input wire thread_idx_t issue_thread,
	input wire register_idx_t issue_dest_reg,
	input wire logic issue_dest_is_vector,
	input wire lane_mask_t issue_mask,
	input wire scalar_t issue_pc,
	input wire line_index_t issue_addr_line,
	input wire byte_offset_t issue_addr_offset,
	input wire subcycle_t issue_subcycle,
	input wire logic fill_en,
	input wire line_index_t fill_index,
	input wire vector_t fill_data,
	mem_result_if.source out
);

	vector_t line_store [LINE_COUNT];
	logic [LINE_COUNT-1:0] line_valid;
	logic accept;

	assign accept = issue_valid && (issue_op inside {OP_LOAD_B, OP_LOAD_BX, OP_LOAD_S,
		OP_LOAD_SX, OP_LOAD_W, OP_LOAD_BLOCK, OP_LOAD_GATHER});

	// Fill port
	always_ff @(posedge clk)
	begin
		if (fill_en)
			line_store[fill_index] <= fill_data;
	end

	// Lines start out invalid and become valid on their first fill
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			line_valid <= '0;
		else if (fill_en)
			line_valid[fill_index] <= 1'b1;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= accept;
	end

	// A fill in the same cycle as a load is not seen by that load
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out.op <= issue_op;
			out.thread <= issue_thread;
			out.dest_reg <= issue_dest_reg;
			out.dest_is_vector <= issue_dest_is_vector;
			out.mask <= issue_mask;
			out.pc <= issue_pc;
			out.subcycle <= issue_subcycle;
			out.offset <= issue_addr_offset;
			out.line_data <= line_store[issue_addr_line];
			out.miss <= !line_valid[issue_addr_line];
		end
	end

endmodule

`default_nettype wire

/* src/scalar_exec.sv */
// Single-cycle arithmetic pipeline
// Lane add and subtract, vector compares, branch targets and call links

`timescale 1ns/1ps
`default_nettype none

module scalar_exec import wb_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic issue_valid,
	input wire exec_op_t issue_op,
	input wire thread_idx_t issue_thread,
	input wire register_idx_t issue_dest_reg,
	input wire logic issue_dest_is_vector,
	input wire lane_mask_t issue_mask,
	input wire scalar_t issue_pc,
	input wire vector_t issue_src_a,
	input wire vector_t issue_src_b,
	exec_result_if.source out
);

	logic accept;
	vector_t result_next;
	lane_mask_t cmp_eq;
	lane_mask_t cmp_lt;

	// Loads belong to the memory pipeline
	assign accept = issue_valid && (issue_op inside {OP_ADD, OP_SUB, OP_CMP_EQ, OP_CMP_LT,
		OP_BRANCH, OP_CALL, OP_ILLEGAL});

	always_comb
	begin
		for (int lane = 0; lane < VECTOR_LANES; lane++)
		begin
			cmp_eq[lane] = issue_src_a[lane] == issue_src_b[lane];
			// Signed less-than
			cmp_lt[lane] = $signed(issue_src_a[lane]) < $signed(issue_src_b[lane]);
		end
	end

	always_comb
	begin
		result_next = '0;
		case (issue_op)
			OP_ADD:
			begin
				for (int lane = 0; lane < VECTOR_LANES; lane++)
					result_next[lane] = issue_src_a[lane] + issue_src_b[lane];
			end

			OP_SUB:
			begin
				for (int lane = 0; lane < VECTOR_LANES; lane++)
					result_next[lane] = issue_src_a[lane] - issue_src_b[lane];
			end

			// One flag per lane, packed into lane 0
			OP_CMP_EQ: result_next[0] = scalar_t'(cmp_eq);
			OP_CMP_LT: result_next[0] = scalar_t'(cmp_lt);

			OP_BRANCH: result_next[0] = issue_src_b[0];

			OP_CALL:
			begin
				result_next[0] = issue_src_b[0];
				result_next[1] = issue_pc + 32'd4;
			end

			default: result_next = '0;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= accept;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out.op <= issue_op;
			out.thread <= issue_thread;
			out.dest_reg <= issue_dest_reg;
			out.dest_is_vector <= issue_dest_is_vector;
			out.mask <= issue_mask;
			out.pc <= issue_pc;
			out.result <= result_next;
			out.rollback_en <= issue_op == OP_BRANCH || issue_op == OP_CALL;
		end
	end

endmodule

`default_nettype wire

/* src/stage_if.sv */
// Result buses from the two pipelines into the writeback stage

`timescale 1ns/1ps
`default_nettype none

interface exec_result_if import wb_pkg::*; ();
	logic valid;
	exec_op_t op;
	thread_idx_t thread;
	register_idx_t dest_reg;
	logic dest_is_vector;
	lane_mask_t mask;
	scalar_t pc;
	vector_t result;
	logic rollback_en;

	modport source(output valid, op, thread, dest_reg, dest_is_vector, mask, pc, result,
		rollback_en);
	modport sink(input valid, op, thread, dest_reg, dest_is_vector, mask, pc, result,
		rollback_en);
endinterface

interface mem_result_if import wb_pkg::*; ();
	logic valid;
	exec_op_t op;
	thread_idx_t thread;
	register_idx_t dest_reg;
	logic dest_is_vector;
	lane_mask_t mask;
	scalar_t pc;
	subcycle_t subcycle;
	byte_offset_t offset;
	vector_t line_data;
	logic miss;

	modport source(output valid, op, thread, dest_reg, dest_is_vector, mask, pc, subcycle,
		offset, line_data, miss);
	modport sink(input valid, op, thread, dest_reg, dest_is_vector, mask, pc, subcycle,
		offset, line_data, miss);
endinterface

`default_nettype wire

/* src/wb_pkg.sv */
// Shared widths, types and encodings for the vector back end
// Lane count and line geometry are fixed here for every block

`default_nettype none

package wb_pkg;

	localparam int SCALAR_WIDTH = 32;
	localparam int VECTOR_LANES = 4;
	localparam int LINE_WORDS = VECTOR_LANES;
	localparam int LINE_BYTES = LINE_WORDS * 4;
	localparam int LINE_COUNT = 8;
	localparam int THREADS = 2;
	localparam int REGISTER_COUNT = 32;

	typedef logic [SCALAR_WIDTH-1:0] scalar_t;

	// Lane 0 sits in the least significant 32 bits
	typedef scalar_t [VECTOR_LANES-1:0] vector_t;

	typedef logic [VECTOR_LANES-1:0] lane_mask_t;
	typedef logic [$clog2(THREADS)-1:0] thread_idx_t;
	typedef logic [$clog2(REGISTER_COUNT)-1:0] register_idx_t;
	typedef logic [$clog2(VECTOR_LANES)-1:0] subcycle_t;
	typedef logic [$clog2(LINE_COUNT)-1:0] line_index_t;
	typedef logic [$clog2(LINE_BYTES)-1:0] byte_offset_t;

	localparam register_idx_t REG_PC = 5'd31;
	localparam scalar_t FAULT_VECTOR_PC = 32'd4;

	typedef enum logic [3:0]
	{
		OP_ADD,
		OP_SUB,
		OP_CMP_EQ,
		OP_CMP_LT,
		OP_BRANCH,
		OP_CALL,
		OP_LOAD_B,
		OP_LOAD_BX,
		OP_LOAD_S,
		OP_LOAD_SX,
		OP_LOAD_W,
		OP_LOAD_BLOCK,
		OP_LOAD_GATHER,
		OP_ILLEGAL
	} exec_op_t;

	typedef enum logic [1:0]
	{
		FR_NONE,
		FR_ILLEGAL_INSTRUCTION
	} fault_reason_t;

	typedef enum logic
	{
		PIPE_SCYCLE_ARITH,
		PIPE_MEM
	} pipeline_sel_t;

endpackage

`default_nettype wire
